// File: design/cache_addr_pkg.sv
`include "cache_defines.svh"

package cache_addr_pkg;

	// data and address types
	typedef logic [`CACHE_WORD_W-1:0]	word_t;		// one data word
	typedef logic [`CACHE_ADDR_W-1:0]	addr_t;		// word address

	// address fields
	typedef logic [`CACHE_TAG_W-1:0]	tag_t;		// block tag
	typedef logic [`CACHE_LINE_W-1:0]	line_t;		// line index
	typedef logic [`CACHE_BLOCK_W-1:0]	offs_t;		// word in block

	// one bit wider than the offset
	typedef logic [`CACHE_BLOCK_W:0]	xfer_cnt_t;

endpackage

// File: design/cache_ctrl.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_ctrl (
	input	logic					clock_i,
	input	logic					resetn_i,

	// core side
	input	logic					core_req_i,
	input	logic					core_rw_i,		// 1 = store
	input	cache_addr_pkg::tag_t	core_tag_i,
	input	cache_addr_pkg::offs_t	core_word_i,
	input	cache_addr_pkg::word_t	core_data_i,
	output	logic					core_done_o,
	output	logic					core_hit_o,
	output	cache_addr_pkg::word_t	core_data_o,

	// memory command
	input	logic					mem_ready_i,
	output	logic					mem_req_o,
	output	logic					mem_rw_o,
	output	cache_addr_pkg::addr_t	mem_addr_o,

	// read buffer, mem -> cache
	input	logic					rd_valid_i,
	input	cache_addr_pkg::word_t	rd_data_i,
	output	logic					rd_ack_o,

	// write buffer, cache -> mem
	input	logic					wr_ready_i,
	output	cache_addr_pkg::word_t	wr_data_o,
	output	logic					wr_ack_o,

	tag_if.ctrl						tag_bus,
	data_if.ctrl					data_bus,
	victim_if.ctrl					vic_bus
);
	import cache_addr_pkg::*;
	import cache_ctrl_pkg::*;

	localparam xfer_cnt_t LAST_XFER = xfer_cnt_t'((1 << `CACHE_BLOCK_W) - 1);

	ctrl_state_e	state_q;
	xfer_cnt_t		xfer_cnt_q;		// words moved in this block
	logic			pend_q;			// held request, retried after fill
	logic			rw_q;
	logic			wb_pend_q;		// block write still to be issued
	addr_t			wb_addr_q;
	line_t			victim_q;
	logic			core_done_q;
	logic			core_hit_q;
	word_t			core_data_q;

	logic			active;
	logic			rw_eff;
	logic			hit_go;
	logic			miss_go;
	logic			fill_go;
	logic			wb_go;
	logic			rd_go;
	logic			wr_go;
	logic			last_word;
	mem_op_e		mem_op;

	// strobes and qualifiers
	// ----------------------------------------------------------------------
	assign active		= (state_q == ST_NORMAL) && (core_req_i || pend_q);
	assign rw_eff		= pend_q ? rw_q : core_rw_i;	// retried op uses stored type
	assign hit_go		= active && tag_bus.hit;
	assign miss_go		= active && !tag_bus.hit;
	assign fill_go		= (state_q == ST_WAIT_READY) && mem_ready_i && !wb_pend_q;
	assign wb_go		= wb_pend_q && mem_ready_i;
	assign rd_go		= (state_q == ST_READ_BUFFER) && rd_valid_i;
	assign wr_go		= (state_q == ST_WRITE_BUFFER) && wr_ready_i;
	assign last_word	= (xfer_cnt_q == LAST_XFER);

	// memory command, read and write never in the same cycle
	assign mem_op		= wb_go ? MEM_WRITE : MEM_READ;
	assign mem_req_o	= fill_go || wb_go;
	assign mem_rw_o		= mem_op;
	assign mem_addr_o	= wb_go ? wb_addr_q : {core_tag_i, {`CACHE_BLOCK_W{1'b0}}};

	assign rd_ack_o		= rd_go;
	assign wr_ack_o		= wr_go;
	assign wr_data_o	= data_bus.rdata;	// victim word at {victim, count}

	assign core_done_o	= core_done_q;
	assign core_hit_o	= core_hit_q;
	assign core_data_o	= core_data_q;

	// tag and victim side
	assign tag_bus.lookup_tag	= core_tag_i;
	assign tag_bus.rd_line		= victim_q;
	assign tag_bus.wr_en		= rd_go && last_word;	// tag lands with last fill word
	assign tag_bus.wr_line		= victim_q;
	assign tag_bus.wr_tag		= core_tag_i;

	assign vic_bus.pick			= fill_go;
	assign vic_bus.mark_dirty	= hit_go && rw_eff;
	assign vic_bus.dirty_line	= tag_bus.hit_line;
	assign vic_bus.clean		= wr_go && last_word;

	// data array port
	always_comb begin
		data_bus.addr	= {tag_bus.hit_line, core_word_i};
		data_bus.we		= 1'b0;
		data_bus.wdata	= core_data_i;
		case (state_q)
			ST_NORMAL: data_bus.we = hit_go && rw_eff;		// store on hit
			ST_WRITE_BUFFER: data_bus.addr = {victim_q, xfer_cnt_q[`CACHE_BLOCK_W-1:0]};
			ST_READ_BUFFER: begin
				data_bus.addr	= {victim_q, xfer_cnt_q[`CACHE_BLOCK_W-1:0]};
				data_bus.we		= rd_go;
				data_bus.wdata	= rd_data_i;
			end
			default: ;
		endcase
	end

	// control sequencing
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q		<= ST_NORMAL;
			xfer_cnt_q	<= '0;
			pend_q		<= 1'b0;
			rw_q		<= 1'b0;
			wb_pend_q	<= 1'b0;
			core_done_q	<= 1'b0;
			core_hit_q	<= 1'b0;
		end else begin
			core_done_q	<= 1'b0;	// one cycle pulse
			core_hit_q	<= 1'b0;

			if (wb_go) wb_pend_q <= 1'b0;	// command has gone out

			case (state_q)
				ST_NORMAL: begin
					if (hit_go) begin
						core_done_q	<= 1'b1;
						core_hit_q	<= !pend_q;		// retry after fill reports a miss
						pend_q		<= 1'b0;
					end else if (miss_go) begin
						pend_q		<= 1'b1;
						rw_q		<= rw_eff;
						state_q		<= ST_WAIT_READY;
					end
				end
				ST_WAIT_READY: if (fill_go) state_q <= ST_VICTIM;
				ST_VICTIM: state_q <= vic_bus.dirty ? ST_WRITE_BUFFER : ST_READ_BUFFER;
				ST_WRITE_BUFFER: begin
					if (wr_go) begin
						if (last_word) begin
							xfer_cnt_q	<= '0;
							wb_pend_q	<= 1'b1;	// whole block is in the buffer
							state_q		<= ST_READ_BUFFER;
						end else begin
							xfer_cnt_q	<= xfer_cnt_q + 1'b1;
						end
					end
				end
				ST_READ_BUFFER: begin
					if (rd_go) begin
						if (last_word) begin
							xfer_cnt_q	<= '0;
							state_q		<= ST_NORMAL;	// held request hits next
						end else begin
							xfer_cnt_q	<= xfer_cnt_q + 1'b1;
						end
					end
				end
				default: state_q <= ST_NORMAL;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clock_i) begin
		if (hit_go) core_data_q <= data_bus.rdata;
		if (state_q == ST_VICTIM) victim_q <= vic_bus.line;
		// victim tag still in place on the first word
		if (wr_go && (xfer_cnt_q == '0))
			wb_addr_q <= {tag_bus.rd_tag, {`CACHE_BLOCK_W{1'b0}}};
	end

	// memory handshake rules
	// ----------------------------------------------------------------------
	a_mem_req: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |-> mem_ready_i)
		else $error("mem_req_o without mem_ready_i");
	a_rd_ack: assert property (@(posedge clock_i) disable iff (!resetn_i)
		rd_ack_o |-> rd_valid_i)
		else $error("rd_ack_o without rd_valid_i");
	a_wr_ack: assert property (@(posedge clock_i) disable iff (!resetn_i)
		wr_ack_o |-> wr_ready_i)
		else $error("wr_ack_o without wr_ready_i");

endmodule

// File: design/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	// controller sequencing
	typedef enum logic [2:0] {
		ST_NORMAL,			// hit check and service
		ST_WAIT_READY,		// wait for memory, issue block read
		ST_VICTIM,			// replacement line pick
		ST_WRITE_BUFFER,	// dirty block -> write buffer
		ST_READ_BUFFER		// read buffer -> cache line
	} ctrl_state_e;

	// memory command opcode, driven on mem_rw_o
	typedef enum logic {
		MEM_READ	= 1'b0,
		MEM_WRITE	= 1'b1
	} mem_op_e;

endpackage

// File: design/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cache geometry
// ----------------------------------------------------------------------

// data word width
`define CACHE_WORD_W	32

// word address width, core and memory side
`define CACHE_ADDR_W	16

`define CACHE_BLOCK_W	2	// log2 words per block
`define CACHE_LINE_W	2	// log2 lines, fully associative

// tag is the word address without the word-in-block field
`define CACHE_TAG_W	(`CACHE_ADDR_W - `CACHE_BLOCK_W)

`endif

// File: design/cache_ifs.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

// tag lookup and tag write
// ----------------------------------------------------------------------
interface tag_if;
	import cache_addr_pkg::*;

	tag_t	lookup_tag;		// tag under test
	logic	wr_en;
	line_t	wr_line;
	tag_t	wr_tag;
	line_t	rd_line;		// line whose tag is read back
	logic	hit;
	line_t	hit_line;
	tag_t	rd_tag;

	modport ctrl (output lookup_tag, wr_en, wr_line, wr_tag, rd_line,
		input hit, hit_line, rd_tag);
	modport store (input lookup_tag, wr_en, wr_line, wr_tag, rd_line,
		output hit, hit_line, rd_tag);
endinterface

// word storage access
// ----------------------------------------------------------------------
interface data_if;
	import cache_addr_pkg::*;

	logic [`CACHE_LINE_W+`CACHE_BLOCK_W-1:0]	addr;	// {line, word}
	logic	we;
	word_t	wdata;
	word_t	rdata;			// same cycle as addr

	modport ctrl (output addr, we, wdata, input rdata);
	modport mem (input addr, we, wdata, output rdata);
endinterface

// replacement choice and dirty tracking
// ----------------------------------------------------------------------
interface victim_if;
	import cache_addr_pkg::*;

	logic	pick;			// one cycle strobe
	logic	mark_dirty;
	line_t	dirty_line;
	logic	clean;			// clear dirty of the chosen line
	line_t	line;			// valid the cycle after pick
	logic	dirty;

	modport ctrl (output pick, mark_dirty, dirty_line, clean, input line, dirty);
	modport sel (input pick, mark_dirty, dirty_line, clean, output line, dirty);
endinterface

// File: design/cache_top.sv
`timescale 1ns/1ns

module cache_top (
	input	logic					clock_i,
	input	logic					resetn_i,

	// core
	input	logic					core_req_i,
	input	logic					core_rw_i,
	input	cache_addr_pkg::tag_t	core_tag_i,
	input	cache_addr_pkg::offs_t	core_word_i,
	input	cache_addr_pkg::word_t	core_data_i,
	output	logic					core_done_o,
	output	logic					core_hit_o,
	output	cache_addr_pkg::word_t	core_data_o,

	// memory command
	input	logic					mem_ready_i,
	output	logic					mem_req_o,
	output	logic					mem_rw_o,
	output	cache_addr_pkg::addr_t	mem_addr_o,

	// read and write buffers
	input	logic					rd_valid_i,
	input	cache_addr_pkg::word_t	rd_data_i,
	output	logic					rd_ack_o,
	input	logic					wr_ready_i,
	output	cache_addr_pkg::word_t	wr_data_o,
	output	logic					wr_ack_o
);

	tag_if		tag_bus ();
	data_if		data_bus ();
	victim_if	vic_bus ();

	// sequencing, owns all external ports
	cache_ctrl u_cache_ctrl (
		.clock_i		(clock_i),
		.resetn_i		(resetn_i),
		.core_req_i		(core_req_i),
		.core_rw_i		(core_rw_i),
		.core_tag_i		(core_tag_i),
		.core_word_i	(core_word_i),
		.core_data_i	(core_data_i),
		.core_done_o	(core_done_o),
		.core_hit_o		(core_hit_o),
		.core_data_o	(core_data_o),
		.mem_ready_i	(mem_ready_i),
		.mem_req_o		(mem_req_o),
		.mem_rw_o		(mem_rw_o),
		.mem_addr_o		(mem_addr_o),
		.rd_valid_i		(rd_valid_i),
		.rd_data_i		(rd_data_i),
		.rd_ack_o		(rd_ack_o),
		.wr_ready_i		(wr_ready_i),
		.wr_data_o		(wr_data_o),
		.wr_ack_o		(wr_ack_o),
		.tag_bus		(tag_bus.ctrl),
		.data_bus		(data_bus.ctrl),
		.vic_bus		(vic_bus.ctrl)
	);

	tag_store u_tag_store (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.tag_bus	(tag_bus.store)
	);

	data_array u_data_array (
		.clock_i	(clock_i),
		.data_bus	(data_bus.mem)
	);

	victim_select u_victim_select (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.vic_bus	(vic_bus.sel)
	);

endmodule

// File: design/data_array.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module data_array (
	input	logic	clock_i,
	data_if.mem		data_bus
);
	import cache_addr_pkg::*;

	// lines x words per block
	localparam int DEPTH = 1 << (`CACHE_LINE_W + `CACHE_BLOCK_W);

	word_t	mem_q [DEPTH];

	// combinational read, same cycle as addr
	assign data_bus.rdata = mem_q[data_bus.addr];

	always_ff @(posedge clock_i) begin
		if (data_bus.we) mem_q[data_bus.addr] <= data_bus.wdata;
	end

endmodule

// File: design/tag_store.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module tag_store (
	input	logic	clock_i,
	input	logic	resetn_i,
	tag_if.store	tag_bus
);
	import cache_addr_pkg::*;

	localparam int NUM_LINES = 1 << `CACHE_LINE_W;

	tag_t					tag_q [NUM_LINES];
	logic [NUM_LINES-1:0]	valid_q;
	logic [NUM_LINES-1:0]	match;

	// parallel compare, empty lines never match
	always_comb begin
		for (int i = 0; i < NUM_LINES; i++)
			match[i] = valid_q[i] && (tag_q[i] == tag_bus.lookup_tag);
	end

	// match vector -> line index
	always_comb begin
		tag_bus.hit_line = '0;
		for (int i = 0; i < NUM_LINES; i++)
			if (match[i]) tag_bus.hit_line = line_t'(i);
	end

	assign tag_bus.hit		= |match;
	assign tag_bus.rd_tag	= tag_q[tag_bus.rd_line];	// writeback address source

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			valid_q <= '0;
		else if (tag_bus.wr_en)
			valid_q[tag_bus.wr_line] <= 1'b1;
	end

	always_ff @(posedge clock_i) begin
		if (tag_bus.wr_en) tag_q[tag_bus.wr_line] <= tag_bus.wr_tag;
	end

	// a block lives in one line only
	a_one_match: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match))
		else $error("tag matches more than one line");

endmodule

// File: design/victim_select.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module victim_select (
	input	logic	clock_i,
	input	logic	resetn_i,
	victim_if.sel	vic_bus
);
	import cache_addr_pkg::*;

	localparam int NUM_LINES = 1 << `CACHE_LINE_W;

	line_t					ptr_q;		// last chosen line
	line_t					ptr_next;
	logic [NUM_LINES-1:0]	dirty_q;
	logic					dirty_sel_q;	// dirty bit of chosen line

	assign ptr_next		= ptr_q + 1'b1;		// wraps
	assign vic_bus.line	= ptr_q;
	assign vic_bus.dirty	= dirty_sel_q;

	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			ptr_q		<= '1;		// first pick rolls over to line 0
			dirty_q		<= '0;
			dirty_sel_q	<= 1'b0;
		end else begin
			if (vic_bus.pick) begin
				ptr_q		<= ptr_next;
				dirty_sel_q	<= dirty_q[ptr_next];
			end
			// store hit on a line
			if (vic_bus.mark_dirty) dirty_q[vic_bus.dirty_line] <= 1'b1;
			if (vic_bus.clean) dirty_q[ptr_q] <= 1'b0;	// victim written out
		end
	end

endmodule

// File: run_sim.sh
#!/bin/bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary -f sim.f --top-module cache_tb -o cache_sim \
	&& ./obj_dir/cache_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
	&& echo "run ok" && exit 0 \
	|| { echo "run failed"; exit 1; }

// File: sim.f
+incdir+design
design/cache_addr_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_ifs.sv
design/cache_ctrl.sv
design/tag_store.sv
design/data_array.sv
design/victim_select.sv
design/cache_top.sv
verif/cache_tb.sv

// File: verif/cache_tb.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_tb;
	import cache_addr_pkg::*;
	import cache_ctrl_pkg::*;

	localparam int MAX_OPS			= 64;
	localparam int LINES			= 1 << `CACHE_LINE_W;
	localparam int BLK_WORDS		= 1 << `CACHE_BLOCK_W;
	localparam int CYCLES_PER_OP	= 400;		// watchdog budget per trace line

	// DUT ports
	logic	clock_i;
	logic	resetn_i;
	logic	core_req_i;
	logic	core_rw_i;
	tag_t	core_tag_i;
	offs_t	core_word_i;
	word_t	core_data_i;
	logic	core_done_o;
	logic	core_hit_o;
	word_t	core_data_o;
	logic	mem_ready_i;
	logic	mem_req_o;
	logic	mem_rw_o;
	addr_t	mem_addr_o;
	logic	rd_valid_i;
	word_t	rd_data_i;
	logic	rd_ack_o;
	logic	wr_ready_i;
	word_t	wr_data_o;
	logic	wr_ack_o;

	// trace contents, one entry per core op
	logic [7:0]	op_a [MAX_OPS];
	tag_t		tag_a [MAX_OPS];
	offs_t		word_a [MAX_OPS];
	word_t		sdata_a [MAX_OPS];
	word_t		ldata_a [MAX_OPS];
	logic		hit_a [MAX_OPS];
	int			blk_a [MAX_OPS];		// expected block writes
	int			n_ops = 0;
	logic		trace_loaded = 1'b0;
	string		cur_name = "reset";

	// memory model with its read and write buffers
	word_t		mem_model [1 << `CACHE_ADDR_W];
	word_t		core_view [1 << `CACHE_ADDR_W];	// memory as the core sees it, stores included
	word_t		rd_q [$];			// fill words on their way in
	word_t		wr_q [$];			// victim words waiting for the block write
	word_t		wb_word;
	int			blk_wr_cnt = 0;
	addr_t		exp_wb_addr = '0;

	// round robin shadow of the line tags
	tag_t		line_tag [LINES];
	int			rr_ptr = LINES - 1;	// first miss goes to line 0

	logic [31:0]	lfsr_state = 32'h104de4d1;
	int				done_cnt = 0;
	int				value_errs = 0;
	int				other_errs = 0;

	cache_top u_cache_top (
		.clock_i		(clock_i),
		.resetn_i		(resetn_i),
		.core_req_i		(core_req_i),
		.core_rw_i		(core_rw_i),
		.core_tag_i		(core_tag_i),
		.core_word_i	(core_word_i),
		.core_data_i	(core_data_i),
		.core_done_o	(core_done_o),
		.core_hit_o		(core_hit_o),
		.core_data_o	(core_data_o),
		.mem_ready_i	(mem_ready_i),
		.mem_req_o		(mem_req_o),
		.mem_rw_o		(mem_rw_o),
		.mem_addr_o		(mem_addr_o),
		.rd_valid_i		(rd_valid_i),
		.rd_data_i		(rd_data_i),
		.rd_ack_o		(rd_ack_o),
		.wr_ready_i		(wr_ready_i),
		.wr_data_o		(wr_data_o),
		.wr_ack_o		(wr_ack_o)
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	task automatic report_mismatch(input string name, input string what,
			input logic [31:0] exp_v, input logic [31:0] act_v);
		value_errs++;
		$display("FAILED %s %s: expected %h, actual %h", name, what, exp_v, act_v);
	endtask

	task automatic report_problem(input string msg);
		other_errs++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// trace reader
	// ----------------------------------------------------------------------
	task automatic load_trace();
		int		fd;
		int		r;
		string	line;
		logic [7:0]	op_c;
		tag_t	t;
		offs_t	w;
		word_t	sd;
		word_t	ld;
		logic	h;
		int		b;
		fd = $fopen("verif/cache_trace.txt", "r");
		if (fd == 0) begin
			report_problem("cannot open verif/cache_trace.txt");
			return;
		end
		while (n_ops < MAX_OPS && $fgets(line, fd) != 0) begin
			if (line.len() < 5 || line.getc(0) == "#") continue;	// comment or blank
			r = $sscanf(line, "%c %h %h %h %h %h %d", op_c, t, w, sd, ld, h, b);
			if (r != 7 || (op_c != "L" && op_c != "S")) begin
				report_problem({"unreadable trace line: ", line});
				continue;
			end
			op_a[n_ops]		= op_c;
			tag_a[n_ops]	= t;
			word_a[n_ops]	= w;
			sdata_a[n_ops]	= sd;
			ldata_a[n_ops]	= ld;
			hit_a[n_ops]	= h;
			blk_a[n_ops]	= b;
			n_ops++;
		end
		$fclose(fd);
	endtask

	task automatic check_idle();
		repeat (5) begin
			@(negedge clock_i);
			if (core_done_o || mem_req_o || rd_ack_o || wr_ack_o)
				report_problem("output strobe active after reset with no request");
		end
	endtask

	// one core request, start to finish
	task automatic run_op(input int i);
		int		cycles;
		int		blk_start;
		logic	is_store;
		is_store = (op_a[i] == "S");
		cur_name = $sformatf("op %0d (%c %h word %0d)", i, op_a[i], tag_a[i], word_a[i]);
		if (!hit_a[i]) begin	// next line in round robin order is the victim
			rr_ptr = (rr_ptr + 1) % LINES;
			exp_wb_addr = {line_tag[rr_ptr], {`CACHE_BLOCK_W{1'b0}}};
			line_tag[rr_ptr] = tag_a[i];
		end
		blk_start	= blk_wr_cnt;
		core_req_i	= 1'b1;
		core_rw_i	= is_store;
		core_tag_i	= tag_a[i];
		core_word_i	= word_a[i];
		core_data_i	= sdata_a[i];
		@(negedge clock_i);
		core_req_i	= 1'b0;		// strobe only, fields held until done
		cycles		= 1;
		while (!core_done_o) begin
			@(negedge clock_i);
			cycles++;
		end
		if (core_hit_o != hit_a[i])
			report_mismatch(cur_name, "hit flag", 32'(hit_a[i]), 32'(core_hit_o));
		if (hit_a[i] && cycles != 1)
			report_mismatch(cur_name, "hit latency", 32'd1, 32'(cycles));
		if (!is_store && core_data_o != ldata_a[i])
			report_mismatch(cur_name, "load data", ldata_a[i], core_data_o);
		if (is_store) core_view[{tag_a[i], word_a[i]}] = sdata_a[i];
		// victim words still buffered, their block write belongs to this op
		while (wr_q.size() != 0) @(negedge clock_i);
		if (blk_wr_cnt - blk_start != blk_a[i])
			report_mismatch(cur_name, "block writes", 32'(blk_a[i]),
				32'(blk_wr_cnt - blk_start));
	endtask

	// clock, memory side drive, memory model
	// ----------------------------------------------------------------------
	initial begin
		clock_i = 1'b0;
		forever #10 clock_i = ~clock_i;
	end

	initial begin
		mem_ready_i	= 1'b0;
		rd_valid_i	= 1'b0;
		rd_data_i	= '0;
		wr_ready_i	= 1'b0;
		forever begin
			@(negedge clock_i);
			mem_ready_i	= next_random_bit() | next_random_bit();	// high 3 of 4
			wr_ready_i	= next_random_bit() | next_random_bit();
			rd_valid_i	= (next_random_bit() | next_random_bit()) && (rd_q.size() != 0);
			rd_data_i	= (rd_q.size() != 0) ? rd_q[0] : '0;
		end
	end

	always @(posedge clock_i) begin
		if (resetn_i) begin
			if (rd_ack_o) begin
				if (rd_q.size() == 0) report_problem("rd_ack_o with an empty read buffer");
				else rd_q.delete(0);
			end
			if (wr_ack_o) wr_q.push_back(wr_data_o);
			if (mem_req_o && mem_rw_o == MEM_WRITE) begin
				blk_wr_cnt++;
				if (mem_addr_o != exp_wb_addr)
					report_mismatch(cur_name, "block write address", 32'(exp_wb_addr),
						32'(mem_addr_o));
				if (wr_q.size() < BLK_WORDS)
					report_problem("block write issued before the victim words arrived");
				else
					for (int k = 0; k < BLK_WORDS; k++) begin
						wb_word = wr_q.pop_front();
						if (wb_word != core_view[mem_addr_o + addr_t'(k)])
							report_mismatch(cur_name, "block write data",
								core_view[mem_addr_o + addr_t'(k)], wb_word);
						mem_model[mem_addr_o + addr_t'(k)] = wb_word;
					end
			end else if (mem_req_o) begin	// block read, snapshot now
				if (rd_q.size() != 0) report_problem("block read while a fill is pending");
				for (int k = 0; k < BLK_WORDS; k++)
					rd_q.push_back(mem_model[mem_addr_o + addr_t'(k)]);
			end
		end
	end

	always @(posedge clock_i)
		if (resetn_i && core_done_o) done_cnt++;

	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		resetn_i	= 1'b0;
		core_req_i	= 1'b0;
		core_rw_i	= 1'b0;
		core_tag_i	= '0;
		core_word_i	= '0;
		core_data_i	= '0;
		for (int a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
			mem_model[a] = 32'hC0DE0000 ^ 32'(a);	// initial memory image
			core_view[a] = mem_model[a];
		end
		for (int l = 0; l < LINES; l++)
			line_tag[l] = '0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (5) @(posedge clock_i);	// reset held for 5 cycles
		@(negedge clock_i);
		resetn_i = 1'b1;
		check_idle();
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		repeat (4) @(negedge clock_i);
		if (done_cnt != n_ops)
			report_problem($sformatf("%0d core_done_o pulses for %0d requests",
				done_cnt, n_ops));
		$display("errors: %0d value mismatches, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0 && n_ops > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// watchdog, sized from the trace length
	initial begin
		wait (trace_loaded);
		repeat ((n_ops + 1) * CYCLES_PER_OP) @(posedge clock_i);
		$display("timeout: run still busy after %0d cycles", (n_ops + 1) * CYCLES_PER_OP);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verif/cache_trace.txt
# op tag word store_data load_data hit block_writes
# all hex except block_writes (decimal); load_data unused for stores
L 0010 0 00000000 c0de0040 0 0
L 0010 1 00000000 c0de0041 1 0
L 0010 3 00000000 c0de0043 1 0
S 0010 2 11112222 00000000 1 0
L 0010 2 00000000 11112222 1 0
L 0020 0 00000000 c0de0080 0 0
S 0020 3 33334444 00000000 1 0
S 0030 1 55556666 00000000 0 0
L 0030 1 00000000 55556666 1 0
L 0040 2 00000000 c0de0102 0 0
L 0050 0 00000000 c0de0140 0 1
L 0060 1 00000000 c0de0181 0 1
L 0070 0 00000000 c0de01c0 0 1
L 0080 3 00000000 c0de0203 0 0
L 0010 2 00000000 11112222 0 0
L 0010 0 00000000 c0de0040 1 0
L 0020 3 00000000 33334444 0 0
L 0030 1 00000000 55556666 0 0
S 0080 3 77778888 00000000 1 0
L 0040 0 00000000 c0de0100 0 1
L 0080 3 00000000 77778888 0 0
L 0080 0 00000000 c0de0200 1 0
L 0020 0 00000000 c0de0080 1 0
